// ==== design/fp_misc_params.svh ====
/*
 * Shared widths and encodings for the FP misc write-back unit
 * Operation select bits, rounding modes, compare functions
 * Exception flag positions and FCLASS bit indices
 */
`ifndef FP_MISC_PARAMS_SVH
`define FP_MISC_PARAMS_SVH

// Word and field widths
`define FP_XLEN     32
`define FP_EXP_W    8
`define FP_MAN_W    23
`define FP_BIAS     127
`define FP_ID_W     3
`define FP_FLAGS_W  5

// Flag bits, NV highest and NX lowest
`define FP_FLAG_NV  4
`define FP_FLAG_NX  0

// One-hot op select bit positions
`define FP_OP_MV    3
`define FP_OP_F2I   2
`define FP_OP_CMP   1
`define FP_OP_CLASS 0

// Rounding modes, already resolved
`define FP_RM_RNE   3'd0
`define FP_RM_RTZ   3'd1
`define FP_RM_RDN   3'd2
`define FP_RM_RUP   3'd3
`define FP_RM_RMM   3'd4

// Compare function, funct3 encoding
`define FP_CMP_FLE  2'd0
`define FP_CMP_FLT  2'd1
`define FP_CMP_FEQ  2'd2

// FCLASS result bit indices
`define FP_CLASS_NEG_INF  0
`define FP_CLASS_NEG_NORM 1
`define FP_CLASS_NEG_SUB  2
`define FP_CLASS_NEG_ZERO 3
`define FP_CLASS_POS_ZERO 4
`define FP_CLASS_POS_SUB  5
`define FP_CLASS_POS_NORM 6
`define FP_CLASS_POS_INF  7
`define FP_CLASS_SNAN     8
`define FP_CLASS_QNAN     9

`endif

// ==== design/fp_misc_pkg.sv ====
/*
 * Types for the FP misc write-back unit
 * Single-precision field struct
 * Word union with raw and field views
 */
`include "fp_misc_params.svh"

package fp_misc_pkg;

    // IEEE 754 single-precision layout
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] man;
    } fp_fields_t;

    // Same 32 bits seen two ways
    // raw for the bit move, f for decoding stages
    typedef union packed {
        logic [`FP_XLEN-1:0] raw;
        fp_fields_t          f;
    } fp_word_u;

endpackage

// ==== design/fp_f2i.sv ====
/*
 * FCVT.W.S / FCVT.WU.S stage
 * Mantissa alignment into a 32.32 fixed-point word
 * Rounding in all five modes, sign apply
 * Saturation with NV, inexact with NX
 * One registered stage held by advance
 */
`timescale 1ns/1ps
`include "fp_misc_params.svh"

module fp_f2i (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic                   new_request,
    input  logic [`FP_ID_W-1:0]    id,
    input  fp_misc_pkg::fp_word_u  a,
    input  logic [2:0]             rm,
    input  logic                   is_signed,
    output logic                   done,
    output logic [`FP_ID_W-1:0]    wb_id,
    output logic [`FP_XLEN-1:0]    rd,
    output logic [`FP_FLAGS_W-1:0] fflags
);

    logic                   is_nan;
    logic                   huge;
    logic                   tiny;
    logic                   nonzero;
    logic [23:0]            sig;
    logic [7:0]             shamt;
    logic [63:0]            fixed;
    logic [31:0]            int_part;
    logic                   guard;
    logic                   sticky;
    logic                   inexact;
    logic                   round_inc;
    logic [32:0]            mag;
    logic                   overflow;
    logic                   invalid;
    logic [`FP_XLEN-1:0]    rd_c;
    logic [`FP_FLAGS_W-1:0] flags_c;

    ////////////////////////////////////////
    // Decode and align

    assign is_nan  = (a.f.exp == 8'hFF) && (a.f.man != '0);
    assign nonzero = (a.raw[30:0] != '0);

    // Unbiased exponent of 32 or more never fits, infinity included
    assign huge = (a.f.exp >= (`FP_BIAS + 32));
    // Below 2^-9 nothing reaches the guard bit
    assign tiny = (a.f.exp < (`FP_BIAS - 9));

    // Hidden bit only for normals
    assign sig = {(a.f.exp != '0), a.f.man};

    // Shift of E+9 puts the binary point between bits 32 and 31
    assign shamt = a.f.exp - 8'(`FP_BIAS - 9);
    assign fixed = {40'b0, sig} << shamt;

    assign int_part = tiny ? 32'b0 : fixed[63:32];
    assign guard    = tiny ? 1'b0  : fixed[31];
    assign sticky   = tiny ? nonzero : (fixed[30:0] != '0);
    assign inexact  = guard | sticky;

    ////////////////////////////////////////
    // Rounding on the magnitude

    always_comb begin
        case (rm)
            `FP_RM_RNE: round_inc = guard & (sticky | int_part[0]);
            `FP_RM_RTZ: round_inc = 1'b0;
            // Toward -inf grows a negative magnitude
            `FP_RM_RDN: round_inc = a.f.sign & inexact;
            `FP_RM_RUP: round_inc = ~a.f.sign & inexact;
            `FP_RM_RMM: round_inc = guard;
            default:    round_inc = 1'b0;
        endcase
    end

    // Extra bit catches the carry out of the increment
    assign mag = {1'b0, int_part} + {32'b0, round_inc};

    ////////////////////////////////////////
    // Range check and saturation

    always_comb begin
        if (huge) begin
            overflow = 1'b1;
        end else if (is_signed) begin
            // Negative side reaches one further, -2^31
            overflow = a.f.sign ? (mag > 33'h0_8000_0000) : (mag > 33'h0_7FFF_FFFF);
        end else begin
            // Negative rounding to zero stays valid
            overflow = a.f.sign ? (mag != '0) : mag[32];
        end
    end

    assign invalid = is_nan | overflow;

    always_comb begin
        if (is_nan) begin
            rd_c = is_signed ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
        end else if (overflow && a.f.sign) begin
            rd_c = is_signed ? 32'h8000_0000 : 32'h0000_0000;
        end else if (overflow) begin
            rd_c = is_signed ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
        end else if (a.f.sign) begin
            rd_c = -mag[31:0];
        end else begin
            rd_c = mag[31:0];
        end
    end

    // NV alone on saturation, else NX when bits dropped
    always_comb begin
        flags_c = '0;
        flags_c[`FP_FLAG_NV] = invalid;
        flags_c[`FP_FLAG_NX] = ~invalid & inexact;
    end

    ////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= new_request;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_id  <= id;
            rd     <= rd_c;
            fflags <= flags_c;
        end
    end

endmodule

// ==== design/fp_cmp.sv ====
/*
 * FEQ / FLT / FLE stage
 * Sign-magnitude ordering with both zeros equal
 * NaN gives 0, NV per function rules
 * One registered stage held by advance
 */
`timescale 1ns/1ps
`include "fp_misc_params.svh"

module fp_cmp (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic                   new_request,
    input  logic [`FP_ID_W-1:0]    id,
    input  fp_misc_pkg::fp_word_u  a,
    input  fp_misc_pkg::fp_word_u  b,
    input  logic [1:0]             cmp_fn,
    output logic                   done,
    output logic [`FP_ID_W-1:0]    wb_id,
    output logic [`FP_XLEN-1:0]    rd,
    output logic [`FP_FLAGS_W-1:0] fflags
);

    logic                   a_nan;
    logic                   b_nan;
    logic                   any_nan;
    logic                   any_snan;
    logic                   both_zero;
    logic                   mag_lt;
    logic                   eq;
    logic                   lt;
    logic                   res;
    logic                   nv;
    logic [`FP_FLAGS_W-1:0] flags_c;

    ////////////////////////////////////////
    // Operand decode

    assign a_nan   = (a.f.exp == 8'hFF) && (a.f.man != '0);
    assign b_nan   = (b.f.exp == 8'hFF) && (b.f.man != '0);
    assign any_nan = a_nan | b_nan;
    // Signaling when the quiet bit is clear
    assign any_snan = (a_nan & ~a.f.man[`FP_MAN_W-1]) | (b_nan & ~b.f.man[`FP_MAN_W-1]);

    // -0 and +0 compare equal
    assign both_zero = (a.raw[30:0] == '0) && (b.raw[30:0] == '0);

    // Exponent then mantissa ordering
    assign mag_lt = {a.f.exp, a.f.man} < {b.f.exp, b.f.man};

    assign eq = (a.raw == b.raw) | both_zero;

    always_comb begin
        if (both_zero) begin
            lt = 1'b0;
        end else if (a.f.sign != b.f.sign) begin
            // Only the negative operand can be smaller
            lt = a.f.sign;
        end else if (a.f.sign) begin
            // Both negative, larger magnitude is smaller
            lt = ~mag_lt & ~eq;
        end else begin
            lt = mag_lt;
        end
    end

    ////////////////////////////////////////
    // Function select and flags

    always_comb begin
        case (cmp_fn)
            `FP_CMP_FEQ: begin
                res = eq;
                nv  = any_snan;
            end
            `FP_CMP_FLT: begin
                res = lt;
                nv  = any_nan;
            end
            `FP_CMP_FLE: begin
                res = lt | eq;
                nv  = any_nan;
            end
            default: begin
                res = 1'b0;
                nv  = 1'b0;
            end
        endcase
    end

    always_comb begin
        flags_c = '0;
        flags_c[`FP_FLAG_NV] = nv;
    end

    ////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= new_request;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_id  <= id;
            // Unordered pairs always give 0
            rd     <= {{(`FP_XLEN-1){1'b0}}, res & ~any_nan};
            fflags <= flags_c;
        end
    end

endmodule

// ==== design/fp_class.sv ====
/*
 * FCLASS stage
 * Exponent and mantissa decode to a one-hot ten-bit mask
 * Flags always zero
 */
`timescale 1ns/1ps
`include "fp_misc_params.svh"

module fp_class (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic                   new_request,
    input  logic [`FP_ID_W-1:0]    id,
    input  fp_misc_pkg::fp_word_u  a,
    output logic                   done,
    output logic [`FP_ID_W-1:0]    wb_id,
    output logic [`FP_XLEN-1:0]    rd,
    output logic [`FP_FLAGS_W-1:0] fflags
);

    logic                exp_max;
    logic                exp_zero;
    logic                man_zero;
    logic [3:0]          cls_idx;
    logic [`FP_XLEN-1:0] rd_c;

    assign exp_max  = (a.f.exp == 8'hFF);
    assign exp_zero = (a.f.exp == '0);
    assign man_zero = (a.f.man == '0);

    // Pick the single class index
    always_comb begin
        if (exp_max && man_zero) begin
            cls_idx = a.f.sign ? 4'(`FP_CLASS_NEG_INF) : 4'(`FP_CLASS_POS_INF);
        end else if (exp_max) begin
            // Top mantissa bit separates quiet from signaling
            cls_idx = a.f.man[`FP_MAN_W-1] ? 4'(`FP_CLASS_QNAN) : 4'(`FP_CLASS_SNAN);
        end else if (exp_zero && man_zero) begin
            cls_idx = a.f.sign ? 4'(`FP_CLASS_NEG_ZERO) : 4'(`FP_CLASS_POS_ZERO);
        end else if (exp_zero) begin
            cls_idx = a.f.sign ? 4'(`FP_CLASS_NEG_SUB) : 4'(`FP_CLASS_POS_SUB);
        end else begin
            cls_idx = a.f.sign ? 4'(`FP_CLASS_NEG_NORM) : 4'(`FP_CLASS_POS_NORM);
        end
    end

    // Zero-extended one-hot mask
    always_comb begin
        rd_c = '0;
        rd_c[cls_idx] = 1'b1;
    end

    ////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= new_request;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_id  <= id;
            rd     <= rd_c;
            fflags <= '0;
        end
    end

endmodule

// ==== design/fp_wb2int_misc.sv ====
/*
 * FP ops writing back to the integer register file
 * Per-stage request gating from the one-hot op select
 * FMV.X.W register, F2I / CMP / CLASS stage instances
 * Shared advance and the write-back output mux
 */
`timescale 1ns/1ps
`include "fp_misc_params.svh"

module fp_wb2int_misc (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   new_request,
    input  logic [`FP_ID_W-1:0]    id,
    input  logic [3:0]             op,
    input  fp_misc_pkg::fp_word_u  rs1,
    input  fp_misc_pkg::fp_word_u  rs2,
    input  logic [2:0]             rm,
    input  logic                   is_signed,
    input  logic [1:0]             cmp_fn,
    output logic                   ready,
    output logic                   done,
    output logic [`FP_ID_W-1:0]    wb_id,
    output logic [`FP_XLEN-1:0]    rd,
    output logic [`FP_FLAGS_W-1:0] fflags,
    input  logic                   ack
);

    logic                   advance;
    logic [3:0]             op_q;

    // Gated requests per stage
    logic                   mv_req;
    logic                   f2i_req;
    logic                   cmp_req;
    logic                   class_req;

    // Stage results
    logic                   mv_done;
    logic [`FP_ID_W-1:0]    mv_id;
    logic [`FP_XLEN-1:0]    mv_rd;
    logic                   f2i_done;
    logic [`FP_ID_W-1:0]    f2i_id;
    logic [`FP_XLEN-1:0]    f2i_rd;
    logic [`FP_FLAGS_W-1:0] f2i_flags;
    logic                   cmp_done;
    logic [`FP_ID_W-1:0]    cmp_id;
    logic [`FP_XLEN-1:0]    cmp_rd;
    logic [`FP_FLAGS_W-1:0] cmp_flags;
    logic                   class_done;
    logic [`FP_ID_W-1:0]    class_id;
    logic [`FP_XLEN-1:0]    class_rd;
    logic [`FP_FLAGS_W-1:0] class_flags;

    ////////////////////////////////////////
    // Issue fan-out and advance

    assign mv_req    = new_request & op[`FP_OP_MV];
    assign f2i_req   = new_request & op[`FP_OP_F2I];
    assign cmp_req   = new_request & op[`FP_OP_CMP];
    assign class_req = new_request & op[`FP_OP_CLASS];

    // Whole unit stalls while a result waits for ack
    assign advance = ack | ~done;
    assign ready   = advance;

    ////////////////////////////////////////
    // FMV.X.W path, raw bits straight into a register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mv_done <= 1'b0;
        end else if (advance) begin
            mv_done <= mv_req;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mv_id <= id;
            mv_rd <= rs1.raw;
        end
    end

    ////////////////////////////////////////
    // Stage instances

    fp_f2i u_f2i (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .new_request (f2i_req),
        .id          (id),
        .a           (rs1),
        .rm          (rm),
        .is_signed   (is_signed),
        .done        (f2i_done),
        .wb_id       (f2i_id),
        .rd          (f2i_rd),
        .fflags      (f2i_flags)
    );

    fp_cmp u_cmp (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .new_request (cmp_req),
        .id          (id),
        .a           (rs1),
        .b           (rs2),
        .cmp_fn      (cmp_fn),
        .done        (cmp_done),
        .wb_id       (cmp_id),
        .rd          (cmp_rd),
        .fflags      (cmp_flags)
    );

    fp_class u_class (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .new_request (class_req),
        .id          (id),
        .a           (rs1),
        .done        (class_done),
        .wb_id       (class_id),
        .rd          (class_rd),
        .fflags      (class_flags)
    );

    ////////////////////////////////////////
    // Op register, last accepted op

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= '0;
        end else if (advance && new_request) begin
            op_q <= op;
        end
    end

    ////////////////////////////////////////
    // Write-back mux

    // Idle op_q of zero falls to CLASS, whose done is low then
    always_comb begin
        if (op_q[`FP_OP_MV]) begin
            done   = mv_done;
            wb_id  = mv_id;
            rd     = mv_rd;
            fflags = '0;
        end else if (op_q[`FP_OP_F2I]) begin
            done   = f2i_done;
            wb_id  = f2i_id;
            rd     = f2i_rd;
            fflags = f2i_flags;
        end else if (op_q[`FP_OP_CMP]) begin
            done   = cmp_done;
            wb_id  = cmp_id;
            rd     = cmp_rd;
            fflags = cmp_flags;
        end else begin
            done   = class_done;
            wb_id  = class_id;
            rd     = class_rd;
            fflags = class_flags;
        end
    end

endmodule

// ==== tb/fp_wb2int_misc_sva.sv ====
/*
 * Bound assertions for the FP misc write-back unit
 * done low in and just after reset
 * ready tracks ack or not done
 * Write-back outputs held while stalled
 */
`timescale 1ns/1ps
`include "fp_misc_params.svh"

module fp_wb2int_misc_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   ready,
    input logic                   done,
    input logic                   ack,
    input logic [`FP_ID_W-1:0]    wb_id,
    input logic [`FP_XLEN-1:0]    rd,
    input logic [`FP_FLAGS_W-1:0] fflags
);

    // Failed assertion count
    int fail_count = 0;

    // No result while reset is held
    a_done_in_reset: assert property (@(posedge clk) !rst_n |-> !done)
        else begin
            $error("done high while reset is asserted");
            fail_count++;
        end

    // First cycle after release still idle
    a_done_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !done)
        else begin
            $error("done high in the first cycle after reset");
            fail_count++;
        end

    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
        ready == (ack || !done))
        else begin
            $error("ready differs from ack or not done");
            fail_count++;
        end

    // Stalled result must not move
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (done && !ack) |=> (done && $stable(wb_id) && $stable(rd) && $stable(fflags)))
        else begin
            $error("write-back outputs changed while stalled");
            fail_count++;
        end

endmodule

bind fp_wb2int_misc fp_wb2int_misc_sva u_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .ready  (ready),
    .done   (done),
    .ack    (ack),
    .wb_id  (wb_id),
    .rd     (rd),
    .fflags (fflags)
);

// ==== tb/fp_wb2int_misc_tb.sv ====
/*
 * Testbench for the FP misc write-back unit
 * Stimulus table with hand-worked rd and fflags per entry
 * Random ack stalls from an xorshift generator, scoreboard queues
 * Typed compare tasks, error counters, cycle watchdog
 */
`timescale 1ns/1ps
`include "fp_misc_params.svh"

module fp_wb2int_misc_tb;

    localparam int N_TESTS    = 52;
    // Last entries run with ack held high
    localparam int FAST_START = N_TESTS - 8;
    localparam int TIMEOUT    = 8 + 4 * N_TESTS + 50;

    localparam logic [3:0] OP_MV    = 4'b0001 << `FP_OP_MV;
    localparam logic [3:0] OP_F2I   = 4'b0001 << `FP_OP_F2I;
    localparam logic [3:0] OP_CMP   = 4'b0001 << `FP_OP_CMP;
    localparam logic [3:0] OP_CLASS = 4'b0001 << `FP_OP_CLASS;

    localparam logic [`FP_FLAGS_W-1:0] F_NONE = '0;
    localparam logic [`FP_FLAGS_W-1:0] F_NV   = 5'b00001 << `FP_FLAG_NV;
    localparam logic [`FP_FLAGS_W-1:0] F_NX   = 5'b00001 << `FP_FLAG_NX;

    // One table row, operands plus expected write-back
    typedef struct packed {
        logic [3:0]             op;
        fp_misc_pkg::fp_word_u  rs1;
        fp_misc_pkg::fp_word_u  rs2;
        logic [2:0]             rm;
        logic                   is_signed;
        logic [1:0]             cmp_fn;
        logic [`FP_XLEN-1:0]    exp_rd;
        logic [`FP_FLAGS_W-1:0] exp_flags;
    } entry_t;

    logic                   clk;
    logic                   rst_n;
    logic                   new_request;
    logic [`FP_ID_W-1:0]    id;
    logic [3:0]             op;
    fp_misc_pkg::fp_word_u  rs1;
    fp_misc_pkg::fp_word_u  rs2;
    logic [2:0]             rm;
    logic                   is_signed;
    logic [1:0]             cmp_fn;
    logic                   ack;
    logic                   ready;
    logic                   done;
    logic [`FP_ID_W-1:0]    wb_id;
    logic [`FP_XLEN-1:0]    rd;
    logic [`FP_FLAGS_W-1:0] fflags;

    entry_t      tbl [N_TESTS];
    int          n_entries;
    int          pend_q[$];   // table indices in issue order
    int          issue_q[$];  // cycle of each accept
    int          next_idx;
    int          n_consumed;
    int          cycle;
    int          value_errors;
    int          protocol_errors;
    logic [31:0] rng;

    fp_wb2int_misc uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_request (new_request),
        .id          (id),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rm          (rm),
        .is_signed   (is_signed),
        .cmp_fn      (cmp_fn),
        .ready       (ready),
        .done        (done),
        .wb_id       (wb_id),
        .rd          (rd),
        .fflags      (fflags),
        .ack         (ack)
    );

    // 20 ns period
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_entry(input logic [3:0] op_v, input logic [31:0] a, input logic [31:0] b,
                             input logic [2:0] rm_v, input logic sgn, input logic [1:0] fn,
                             input logic [`FP_XLEN-1:0] exp_rd,
                             input logic [`FP_FLAGS_W-1:0] exp_fl);
        entry_t e;
        e.op        = op_v;
        e.rs1.raw   = a;
        e.rs2.raw   = b;
        e.rm        = rm_v;
        e.is_signed = sgn;
        e.cmp_fn    = fn;
        e.exp_rd    = exp_rd;
        e.exp_flags = exp_fl;
        if (n_entries < N_TESTS) begin
            tbl[n_entries] = e;
        end
        n_entries++;
    endtask

    task automatic check_rd(input logic [`FP_XLEN-1:0] got, input logic [`FP_XLEN-1:0] exp,
                            input int k);
        if (got !== exp) begin
            $display("FAILED t=%0t entry %0d: rd %h, expected %h", $time, k, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flags(input logic [`FP_FLAGS_W-1:0] got,
                               input logic [`FP_FLAGS_W-1:0] exp, input int k);
        if (got !== exp) begin
            $display("FAILED t=%0t entry %0d: fflags %b, expected %b", $time, k, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_id(input logic [`FP_ID_W-1:0] got, input logic [`FP_ID_W-1:0] exp,
                            input int k);
        if (got !== exp) begin
            $display("FAILED t=%0t entry %0d: wb_id %0d, expected %0d", $time, k, got, exp);
            value_errors++;
        end
    endtask

    task automatic print_counts;
        $display("Errors: %0d value mismatches, %0d protocol errors, %0d assertion failures",
                 value_errors, protocol_errors, uut.u_sva.fail_count);
    endtask

    ////////////////////////////////////////
    // Stimulus table

    task automatic build_table;
        // FMV.X.W, raw bits whatever they encode
        add_entry(OP_MV, 32'h3F800000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h3F800000, F_NONE);
        add_entry(OP_MV, 32'hC0490FDB, 32'hFFFFFFFF, 3'd0, 1'b0, 2'd0, 32'hC0490FDB, F_NONE);
        add_entry(OP_MV, 32'h7FC00001, 32'h0, 3'd0, 1'b0, 2'd0, 32'h7FC00001, F_NONE);
        // 2.5 in every rounding mode
        add_entry(OP_F2I, 32'h40200000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'h2, F_NX);
        add_entry(OP_F2I, 32'h40200000, 32'h0, `FP_RM_RUP, 1'b1, 2'd0, 32'h3, F_NX);
        add_entry(OP_F2I, 32'h40200000, 32'h0, `FP_RM_RTZ, 1'b1, 2'd0, 32'h2, F_NX);
        add_entry(OP_F2I, 32'h40200000, 32'h0, `FP_RM_RDN, 1'b1, 2'd0, 32'h2, F_NX);
        add_entry(OP_F2I, 32'h40200000, 32'h0, `FP_RM_RMM, 1'b1, 2'd0, 32'h3, F_NX);
        // -2.5, toward -inf and away from zero give -3
        add_entry(OP_F2I, 32'hC0200000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'hFFFFFFFE, F_NX);
        add_entry(OP_F2I, 32'hC0200000, 32'h0, `FP_RM_RUP, 1'b1, 2'd0, 32'hFFFFFFFE, F_NX);
        add_entry(OP_F2I, 32'hC0200000, 32'h0, `FP_RM_RTZ, 1'b1, 2'd0, 32'hFFFFFFFE, F_NX);
        add_entry(OP_F2I, 32'hC0200000, 32'h0, `FP_RM_RDN, 1'b1, 2'd0, 32'hFFFFFFFD, F_NX);
        add_entry(OP_F2I, 32'hC0200000, 32'h0, `FP_RM_RMM, 1'b1, 2'd0, 32'hFFFFFFFD, F_NX);
        // 1.75 inexact, 100.0 exact
        add_entry(OP_F2I, 32'h3FE00000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'h2, F_NX);
        add_entry(OP_F2I, 32'h42C80000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'h64, F_NONE);
        // Saturation cases
        add_entry(OP_F2I, 32'h7FC00000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'h7FFFFFFF, F_NV);
        add_entry(OP_F2I, 32'h7FC00000, 32'h0, `FP_RM_RNE, 1'b0, 2'd0, 32'hFFFFFFFF, F_NV);
        add_entry(OP_F2I, 32'h4F32D05E, 32'h0, `FP_RM_RTZ, 1'b1, 2'd0, 32'h7FFFFFFF, F_NV);
        add_entry(OP_F2I, 32'h4F32D05E, 32'h0, `FP_RM_RTZ, 1'b0, 2'd0, 32'hB2D05E00, F_NONE);
        add_entry(OP_F2I, 32'hBF800000, 32'h0, `FP_RM_RNE, 1'b0, 2'd0, 32'h0, F_NV);
        add_entry(OP_F2I, 32'hBF800000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'hFFFFFFFF, F_NONE);
        // -0.3 unsigned truncates to zero, not invalid
        add_entry(OP_F2I, 32'hBE99999A, 32'h0, `FP_RM_RTZ, 1'b0, 2'd0, 32'h0, F_NX);
        add_entry(OP_F2I, 32'hCF000000, 32'h0, `FP_RM_RNE, 1'b1, 2'd0, 32'h80000000, F_NONE);
        // Compares, ordered pairs first
        add_entry(OP_CMP, 32'h80000000, 32'h00000000, 3'd0, 1'b0, `FP_CMP_FEQ, 32'd1, F_NONE);
        add_entry(OP_CMP, 32'h3F800000, 32'h40000000, 3'd0, 1'b0, `FP_CMP_FLT, 32'd1, F_NONE);
        add_entry(OP_CMP, 32'h40000000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FLT, 32'd0, F_NONE);
        add_entry(OP_CMP, 32'h3F800000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FLE, 32'd1, F_NONE);
        add_entry(OP_CMP, 32'hC0000000, 32'hBF800000, 3'd0, 1'b0, `FP_CMP_FLT, 32'd1, F_NONE);
        add_entry(OP_CMP, 32'hBF800000, 32'hC0000000, 3'd0, 1'b0, `FP_CMP_FLE, 32'd0, F_NONE);
        add_entry(OP_CMP, 32'hBF800000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FLT, 32'd1, F_NONE);
        // NaN operands, NV depends on function and NaN kind
        add_entry(OP_CMP, 32'h7FC00000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FEQ, 32'd0, F_NONE);
        add_entry(OP_CMP, 32'h7FC00000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FLT, 32'd0, F_NV);
        add_entry(OP_CMP, 32'h3F800000, 32'h7FC00000, 3'd0, 1'b0, `FP_CMP_FLE, 32'd0, F_NV);
        add_entry(OP_CMP, 32'h7F800001, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FEQ, 32'd0, F_NV);
        // One input per FCLASS bit, bit 0 upward
        add_entry(OP_CLASS, 32'hFF800000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h001, F_NONE);
        add_entry(OP_CLASS, 32'hBF800000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h002, F_NONE);
        add_entry(OP_CLASS, 32'h80000001, 32'h0, 3'd0, 1'b0, 2'd0, 32'h004, F_NONE);
        add_entry(OP_CLASS, 32'h80000000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h008, F_NONE);
        add_entry(OP_CLASS, 32'h00000000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h010, F_NONE);
        add_entry(OP_CLASS, 32'h00000001, 32'h0, 3'd0, 1'b0, 2'd0, 32'h020, F_NONE);
        add_entry(OP_CLASS, 32'h3F800000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h040, F_NONE);
        add_entry(OP_CLASS, 32'h7F800000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h080, F_NONE);
        add_entry(OP_CLASS, 32'h7F800001, 32'h0, 3'd0, 1'b0, 2'd0, 32'h100, F_NONE);
        add_entry(OP_CLASS, 32'h7FC00000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h200, F_NONE);
        // Back-to-back mix, ack held high from here on
        add_entry(OP_MV, 32'h12345678, 32'h0, 3'd0, 1'b0, 2'd0, 32'h12345678, F_NONE);
        add_entry(OP_F2I, 32'h3FE00000, 32'h0, `FP_RM_RTZ, 1'b1, 2'd0, 32'h1, F_NX);
        add_entry(OP_CMP, 32'h3F800000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FEQ, 32'd1, F_NONE);
        add_entry(OP_CLASS, 32'h3F800000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h040, F_NONE);
        add_entry(OP_MV, 32'hDEADBEEF, 32'h0, 3'd0, 1'b0, 2'd0, 32'hDEADBEEF, F_NONE);
        add_entry(OP_F2I, 32'hC0200000, 32'h0, `FP_RM_RMM, 1'b1, 2'd0, 32'hFFFFFFFD, F_NX);
        add_entry(OP_CMP, 32'h7FC00000, 32'h3F800000, 3'd0, 1'b0, `FP_CMP_FLT, 32'd0, F_NV);
        add_entry(OP_CLASS, 32'h7FC00000, 32'h0, 3'd0, 1'b0, 2'd0, 32'h200, F_NONE);
    endtask

    ////////////////////////////////////////
    // Per-edge scoreboard and driver

    // done must match whether a result is in flight
    task automatic retire_result;
        int k;
        int t;
        if (done !== (pend_q.size() != 0)) begin
            $display("Protocol error at %0t: done is %b with %0d results pending",
                     $time, done, pend_q.size());
            protocol_errors++;
        end
        if (done === 1'b1 && ack === 1'b1 && pend_q.size() != 0) begin
            k = pend_q.pop_front();
            t = issue_q.pop_front();
            check_id(wb_id, k[`FP_ID_W-1:0], k);
            check_rd(rd, tbl[k].exp_rd, k);
            check_flags(fflags, tbl[k].exp_flags, k);
            // Full-rate section, each result consumed the cycle after issue
            if (k >= FAST_START && cycle != t + 1) begin
                $display("FAILED t=%0t entry %0d: consumed %0d cycles after issue, expected 1",
                         $time, k, cycle - t);
                value_errors++;
            end
            n_consumed++;
        end
    endtask

    task automatic accept_request;
        if (new_request === 1'b1) begin
            if (ready === 1'b1) begin
                pend_q.push_back(next_idx);
                issue_q.push_back(cycle);
                next_idx++;
            end else begin
                $display("Protocol error at %0t: entry %0d presented while ready is low",
                         $time, next_idx);
                protocol_errors++;
            end
        end
    endtask

    task automatic drive_inputs;
        logic ack_next;
        logic next_ready;
        if (next_idx >= FAST_START) begin
            ack_next = 1'b1;
        end else begin
            rng      = xorshift32(rng);
            ack_next = rng[31];
        end
        // Advance rule, ack or nothing in flight
        next_ready = ack_next | (pend_q.size() == 0);
        ack <= ack_next;
        if (next_ready && next_idx < N_TESTS) begin
            new_request <= 1'b1;
            id          <= next_idx[`FP_ID_W-1:0];
            op          <= tbl[next_idx].op;
            rs1         <= tbl[next_idx].rs1;
            rs2         <= tbl[next_idx].rs2;
            rm          <= tbl[next_idx].rm;
            is_signed   <= tbl[next_idx].is_signed;
            cmp_fn      <= tbl[next_idx].cmp_fn;
        end else begin
            new_request <= 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        new_request     = 1'b0;
        id              = '0;
        op              = '0;
        rs1             = '0;
        rs2             = '0;
        rm              = '0;
        is_signed       = 1'b0;
        cmp_fn          = '0;
        ack             = 1'b0;
        rng             = 32'd68858;
        n_entries       = 0;
        next_idx        = 0;
        n_consumed      = 0;
        value_errors    = 0;
        protocol_errors = 0;
        build_table();
        if (n_entries != N_TESTS) begin
            $display("Stimulus table holds %0d entries, %0d expected", n_entries, N_TESTS);
            protocol_errors++;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (n_consumed < N_TESTS) begin
            @(posedge clk);
            retire_result();
            accept_request();
            drive_inputs();
        end
        @(posedge clk);
        if (done !== 1'b0) begin
            $display("Protocol error at %0t: done still high after the last result", $time);
            protocol_errors++;
        end
        print_counts();
        if (value_errors + protocol_errors + uut.u_sva.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog, limit from reset length and table size
    initial begin : watchdog
        wait (cycle >= TIMEOUT);
        $display("Timeout: run hung after %0d cycles, %0d of %0d results consumed",
                 cycle, n_consumed, N_TESTS);
        protocol_errors++;
        print_counts();
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/fp_misc_pkg.sv
design/fp_f2i.sv
design/fp_cmp.sv
design/fp_class.sv
design/fp_wb2int_misc.sv
tb/fp_wb2int_misc_sva.sv
tb/fp_wb2int_misc_tb.sv
